//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := btb_tb
FILELIST  := files.f
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
+incdir+verilog
verilog/btb_pkg.sv
verilog/btb_index_decode.sv
verilog/btb_set.sv
verilog/btb_hit_select.sv
verilog/btb_top.sv
verification/btb_tb.sv

//--- verification/btb_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "btb_settings.svh"

module btb_tb
	import btb_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 6000;
	localparam int RANDOM_CYCLES  = 4000;
	localparam btb_lookup_t NO_LOOKUP = '0;
	localparam btb_update_t NO_UPDATE = '0;

	logic        clock;
	logic        reset;
	btb_lookup_t lookup_0;
	btb_lookup_t lookup_1;
	btb_update_t update_0;
	btb_update_t update_1;
	btb_result_t result_0;
	btb_result_t result_1;

	btb_entry_t model_way [`BTB_SETS][2]; // reference copy of every set
	logic       model_victim [`BTB_SETS];
	integer     seed;

	btb_top i_btb_top (
		.clock    (clock),
		.reset    (reset),
		.lookup_0 (lookup_0),
		.lookup_1 (lookup_1),
		.update_0 (update_0),
		.update_1 (update_1),
		.result_0 (result_0),
		.result_1 (result_1)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// pc layout is tag, set index, two dropped bits
	function automatic int pc_set(logic [`BTB_PC_WIDTH-1:0] pc);
		return int'(pc[INDEX_WIDTH+1:2]);
	endfunction

	function automatic logic [TAG_WIDTH-1:0] pc_tag_bits(logic [`BTB_PC_WIDTH-1:0] pc);
		return pc[`BTB_PC_WIDTH-1:INDEX_WIDTH+2];
	endfunction

	function automatic logic [`BTB_PC_WIDTH-1:0] make_pc(int set, int tag_id, logic [1:0] low);
		return {TAG_WIDTH'(tag_id), INDEX_WIDTH'(set), low};
	endfunction

	function automatic btb_lookup_t lk(logic [`BTB_PC_WIDTH-1:0] pc);
		return '{valid: 1'b1, pc: pc};
	endfunction

	function automatic btb_update_t up(
		logic [`BTB_PC_WIDTH-1:0] pc,
		logic [`BTB_PC_WIDTH-1:0] tgt
	);
		return '{valid: 1'b1, pc: pc, target: tgt};
	endfunction

	// expected result of one fetch lookup on the current model state
	function automatic btb_result_t expected_result(btb_lookup_t lookup);
		btb_result_t r;
		int          s;
		r = '0;
		if (lookup.valid) begin
			s = pc_set(lookup.pc);
			for (int w = 0; w < 2; w++) begin
				if (model_way[s][w].valid &&
					model_way[s][w].tag == pc_tag_bits(lookup.pc)) begin
					r.hit    = 1'b1;
					r.target = model_way[s][w].target;
				end
			end
		end
		return r;
	endfunction

	task automatic reset_model();
		for (int s = 0; s < `BTB_SETS; s++) begin
			model_way[s][0] = '0;
			model_way[s][1] = '0;
			model_victim[s] = 1'b0;
		end
	endtask

	task automatic touch_model(btb_lookup_t lookup);
		int s;
		logic [TAG_WIDTH-1:0] tag;
		if (lookup.valid) begin
			s   = pc_set(lookup.pc);
			tag = pc_tag_bits(lookup.pc);
			if (model_way[s][0].valid && model_way[s][0].tag == tag) begin
				model_victim[s] = 1'b1;
			end else if (model_way[s][1].valid && model_way[s][1].tag == tag) begin
				model_victim[s] = 1'b0;
			end
		end
	endtask

	task automatic write_model(btb_update_t update);
		int s;
		logic [TAG_WIDTH-1:0] tag;
		logic way;
		if (update.valid) begin
			s   = pc_set(update.pc);
			tag = pc_tag_bits(update.pc);
			if (model_way[s][0].valid && model_way[s][0].tag == tag) begin
				way = 1'b0; // same tag, overwrite in place
			end else if (model_way[s][1].valid && model_way[s][1].tag == tag) begin
				way = 1'b1;
			end else if (!model_way[s][0].valid) begin
				way = 1'b0;
			end else if (!model_way[s][1].valid) begin
				way = 1'b1;
			end else begin
				way = model_victim[s];
			end
			model_way[s][way] = '{valid: 1'b1, tag: tag, target: update.target};
			model_victim[s]   = ~way;
		end
	endtask

	task automatic check_result(btb_result_t actual, btb_result_t expected, string name);
		if (actual !== expected) begin
			$display("MISMATCH %s: hit %h target %h, expected hit %h target %h",
				name, actual.hit, actual.target, expected.hit, expected.target);
			$display("TEST RESULT: FAIL");
			$fatal(1, "result compare failed at %0t", $time);
		end
	endtask

	task automatic drive_cycle(
		btb_lookup_t l0,
		btb_lookup_t l1,
		btb_update_t u0,
		btb_update_t u1
	);
		@(negedge clock);
		lookup_0 = l0;
		lookup_1 = l1;
		update_0 = u0;
		update_1 = u1;
	endtask

	task automatic random_cycle();
		logic [31:0] r0;
		logic [31:0] r1;
		r0 = $random(seed);
		r1 = $random(seed);
		// four sets and four tags keep the ways busy
		drive_cycle(
			'{valid: r0[0], pc: make_pc(int'(r0[3:2]), int'(r0[5:4]), r0[7:6])},
			'{valid: r0[8], pc: make_pc(int'(r0[11:10]), int'(r0[13:12]), r0[15:14])},
			'{valid: r1[0], pc: make_pc(int'(r1[3:2]), int'(r1[5:4]), r1[7:6]),
				target: {$random(seed), $random(seed)}},
			'{valid: r1[8], pc: make_pc(int'(r1[11:10]), int'(r1[13:12]), r1[15:14]),
				target: {$random(seed), $random(seed)}});
	endtask

	// checks just before each rising edge, then steps the model
	initial begin
		btb_result_t exp_0;
		btb_result_t exp_1;
		forever begin
			@(negedge clock);
			#4;
			if (!reset) begin
				exp_0 = expected_result(lookup_0);
				exp_1 = expected_result(lookup_1);
				check_result(result_0, exp_0, "result_0");
				check_result(result_1, exp_1, "result_1");
			end
			@(posedge clock);
			if (reset) begin
				reset_model();
			end else begin
				touch_model(lookup_0);
				touch_model(lookup_1);
				write_model(update_0);
				write_model(update_1);
			end
		end
	end

	initial begin
		for (int c = 0; c < TIMEOUT_CYCLES; c++) begin
			@(posedge clock);
		end
		$display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		seed     = 32'hc863;
		reset    = 1'b1;
		lookup_0 = NO_LOOKUP;
		lookup_1 = NO_LOOKUP;
		update_0 = NO_UPDATE;
		update_1 = NO_UPDATE;
		reset_model();
		repeat (8) @(negedge clock);
		reset = 1'b0;

		drive_cycle(lk(make_pc(2, 7, 2'd1)), lk(make_pc(9, 3, 2'd0)), NO_UPDATE, NO_UPDATE);
		// same-cycle lookup misses, next cycle hits
		drive_cycle(lk(make_pc(3, 1, 2'd0)), NO_LOOKUP,
			up(make_pc(3, 1, 2'd0), 64'h1000), NO_UPDATE);
		drive_cycle(lk(make_pc(3, 1, 2'd0)), lk(make_pc(3, 1, 2'd3)), NO_UPDATE, NO_UPDATE);
		// three tags into set 5, then a touch moves the victim
		drive_cycle(NO_LOOKUP, NO_LOOKUP, up(make_pc(5, 1, 2'd0), 64'h5100), NO_UPDATE);
		drive_cycle(NO_LOOKUP, NO_LOOKUP, up(make_pc(5, 2, 2'd0), 64'h5200), NO_UPDATE);
		drive_cycle(NO_LOOKUP, NO_LOOKUP, up(make_pc(5, 3, 2'd0), 64'h5300), NO_UPDATE);
		drive_cycle(lk(make_pc(5, 1, 2'd0)), lk(make_pc(5, 2, 2'd0)), NO_UPDATE, NO_UPDATE);
		drive_cycle(NO_LOOKUP, NO_LOOKUP, up(make_pc(5, 4, 2'd0), 64'h5400), NO_UPDATE);
		drive_cycle(lk(make_pc(5, 2, 2'd0)), lk(make_pc(5, 3, 2'd0)), NO_UPDATE, NO_UPDATE);
		drive_cycle(lk(make_pc(5, 4, 2'd0)), NO_LOOKUP, NO_UPDATE, NO_UPDATE);
		// dual updates: two sets, one set two tags, one set one tag
		drive_cycle(NO_LOOKUP, NO_LOOKUP, up(make_pc(6, 1, 2'd0), 64'h6100),
			up(make_pc(7, 1, 2'd0), 64'h7100));
		drive_cycle(lk(make_pc(6, 1, 2'd0)), lk(make_pc(7, 1, 2'd0)),
			up(make_pc(8, 1, 2'd0), 64'h8100), up(make_pc(8, 2, 2'd0), 64'h8200));
		drive_cycle(lk(make_pc(8, 1, 2'd0)), lk(make_pc(8, 2, 2'd0)),
			up(make_pc(9, 5, 2'd0), 64'h9a00), up(make_pc(9, 5, 2'd0), 64'h9b00));
		drive_cycle(lk(make_pc(9, 5, 2'd0)), NO_LOOKUP, NO_UPDATE, NO_UPDATE);
		// overwrite an existing tag, the other way stays
		drive_cycle(NO_LOOKUP, NO_LOOKUP, up(make_pc(8, 2, 2'd0), 64'h8222), NO_UPDATE);
		drive_cycle(lk(make_pc(8, 1, 2'd0)), lk(make_pc(8, 2, 2'd0)), NO_UPDATE, NO_UPDATE);

		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			random_cycle();
		end
		drive_cycle(NO_LOOKUP, NO_LOOKUP, NO_UPDATE, NO_UPDATE);
		drive_cycle(NO_LOOKUP, NO_LOOKUP, NO_UPDATE, NO_UPDATE);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/btb_hit_select.sv
`timescale 1ns/1ns
`default_nettype none

`include "btb_settings.svh"

module btb_hit_select
	import btb_pkg::*;
(
	input  btb_set_resp_t [`BTB_SETS-1:0] set_resp,
	output btb_result_t                   result_0,
	output btb_result_t                   result_1
);

	logic [`BTB_SETS-1:0] hit_0; // per set hit flags
	logic [`BTB_SETS-1:0] hit_1;

	always_comb begin
		for (int s = 0; s < `BTB_SETS; s++) begin
			hit_0[s] = set_resp[s].hit_0;
			hit_1[s] = set_resp[s].hit_1;
		end
	end

	// and-or mux, only one set can be selected per port
	// so a miss leaves the target at zero
	always_comb begin
		result_0.hit    = |hit_0;
		result_0.target = '0;
		result_1.hit    = |hit_1;
		result_1.target = '0;
		for (int s = 0; s < `BTB_SETS; s++) begin
			if (hit_0[s]) begin
				result_0.target = result_0.target | set_resp[s].target_0;
			end
			if (hit_1[s]) begin
				result_1.target = result_1.target | set_resp[s].target_1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/btb_index_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "btb_settings.svh"

module btb_index_decode
	import btb_pkg::*;
(
	input  btb_lookup_t                    lookup_0,
	input  btb_lookup_t                    lookup_1,
	input  btb_update_t                    update_0,
	input  btb_update_t                    update_1,
	output btb_set_req_t [`BTB_SETS-1:0]   set_req
);

	// pc layout: [tag | index | 2'b00]
	function automatic logic [INDEX_WIDTH-1:0] pc_index(input logic [`BTB_PC_WIDTH-1:0] pc);
		return pc[INDEX_WIDTH+1:2];
	endfunction

	function automatic logic [TAG_WIDTH-1:0] pc_tag(input logic [`BTB_PC_WIDTH-1:0] pc);
		return pc[`BTB_PC_WIDTH-1:INDEX_WIDTH+2];
	endfunction

	logic [INDEX_WIDTH-1:0] lookup_index_0;
	logic [INDEX_WIDTH-1:0] lookup_index_1;
	logic [INDEX_WIDTH-1:0] update_index_0;
	logic [INDEX_WIDTH-1:0] update_index_1;
	logic [TAG_WIDTH-1:0]   lookup_tag_0;
	logic [TAG_WIDTH-1:0]   lookup_tag_1;
	logic [TAG_WIDTH-1:0]   update_tag_0;
	logic [TAG_WIDTH-1:0]   update_tag_1;

	assign lookup_index_0 = pc_index(lookup_0.pc);
	assign lookup_index_1 = pc_index(lookup_1.pc);
	assign update_index_0 = pc_index(update_0.pc);
	assign update_index_1 = pc_index(update_1.pc);
	assign lookup_tag_0   = pc_tag(lookup_0.pc);
	assign lookup_tag_1   = pc_tag(lookup_1.pc);
	assign update_tag_0   = pc_tag(update_0.pc);
	assign update_tag_1   = pc_tag(update_1.pc);

	// tags and targets fan out to all sets, selects are one-hot per port
	always_comb begin
		for (int s = 0; s < `BTB_SETS; s++) begin
			set_req[s].lookup_sel_0    = lookup_0.valid && (lookup_index_0 == INDEX_WIDTH'(s));
			set_req[s].lookup_tag_0    = lookup_tag_0;
			set_req[s].lookup_sel_1    = lookup_1.valid && (lookup_index_1 == INDEX_WIDTH'(s));
			set_req[s].lookup_tag_1    = lookup_tag_1;
			set_req[s].update_sel_0    = update_0.valid && (update_index_0 == INDEX_WIDTH'(s));
			set_req[s].update_tag_0    = update_tag_0;
			set_req[s].update_target_0 = update_0.target;
			set_req[s].update_sel_1    = update_1.valid && (update_index_1 == INDEX_WIDTH'(s));
			set_req[s].update_tag_1    = update_tag_1;
			set_req[s].update_target_1 = update_1.target;
		end
	end

endmodule

`default_nettype wire

//--- verilog/btb_pkg.sv
`default_nettype none

`include "btb_settings.svh"

package btb_pkg;

	localparam int INDEX_WIDTH = $clog2(`BTB_SETS); // set select bits
	localparam int TAG_WIDTH   = `BTB_PC_WIDTH - INDEX_WIDTH - 2; // pc[1:0] dropped

	typedef struct packed {
		logic                     valid; // fetch slot is live
		logic [`BTB_PC_WIDTH-1:0] pc;
	} btb_lookup_t;

	typedef struct packed {
		logic                     valid; // resolved taken branch
		logic [`BTB_PC_WIDTH-1:0] pc;
		logic [`BTB_PC_WIDTH-1:0] target;
	} btb_update_t;

	typedef struct packed {
		logic                     hit;
		logic [`BTB_PC_WIDTH-1:0] target; // zero on miss
	} btb_result_t;

	typedef struct packed {
		logic                     valid;
		logic [TAG_WIDTH-1:0]     tag;
		logic [`BTB_PC_WIDTH-1:0] target;
	} btb_entry_t;

	// everything one set needs to know about the current cycle
	typedef struct packed {
		logic                     lookup_sel_0; // lookup 0 indexes this set
		logic [TAG_WIDTH-1:0]     lookup_tag_0;
		logic                     lookup_sel_1;
		logic [TAG_WIDTH-1:0]     lookup_tag_1;
		logic                     update_sel_0; // update 0 indexes this set
		logic [TAG_WIDTH-1:0]     update_tag_0;
		logic [`BTB_PC_WIDTH-1:0] update_target_0;
		logic                     update_sel_1;
		logic [TAG_WIDTH-1:0]     update_tag_1;
		logic [`BTB_PC_WIDTH-1:0] update_target_1;
	} btb_set_req_t;

	typedef struct packed {
		logic                     hit_0;
		logic [`BTB_PC_WIDTH-1:0] target_0; // only meaningful with hit_0
		logic                     hit_1;
		logic [`BTB_PC_WIDTH-1:0] target_1;
	} btb_set_resp_t;

endpackage

`default_nettype wire

//--- verilog/btb_set.sv
`timescale 1ns/1ns
`default_nettype none

`include "btb_settings.svh"

module btb_set
	import btb_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  btb_set_req_t  req,
	output btb_set_resp_t resp
);

	btb_entry_t [1:0] way_q; // current contents
	btb_entry_t [1:0] way_d;
	logic             victim_q; // way to evict next
	logic             victim_d;

	logic [1:0] hit_0; // per way, lookup port 0
	logic [1:0] hit_1;
	logic       wr_way_0; // way chosen by update port 0
	logic       wr_way_1;

	// one bit per way, set when that way is valid and holds the tag
	function automatic logic [1:0] match_ways(
		input btb_entry_t [1:0]     ways,
		input logic [TAG_WIDTH-1:0] tag
	);
		logic [1:0] match;
		for (int w = 0; w < 2; w++) begin
			match[w] = ways[w].valid && (ways[w].tag == tag);
		end
		return match;
	endfunction

	// replacement choice: same tag, then free way (way 0 first), then victim
	function automatic logic pick_way(
		input btb_entry_t [1:0]     ways,
		input logic                 victim,
		input logic [TAG_WIDTH-1:0] tag
	);
		logic [1:0] match;
		logic       way;
		match = match_ways(ways, tag);
		if (match[0]) begin
			way = 1'b0;
		end else if (match[1]) begin
			way = 1'b1;
		end else if (!ways[0].valid) begin
			way = 1'b0;
		end else if (!ways[1].valid) begin
			way = 1'b1;
		end else begin
			way = victim;
		end
		return way;
	endfunction

	// lookups see the registered state only
	assign hit_0 = req.lookup_sel_0 ? match_ways(way_q, req.lookup_tag_0) : 2'b00;
	assign hit_1 = req.lookup_sel_1 ? match_ways(way_q, req.lookup_tag_1) : 2'b00;

	// a tag lives in at most one way, so a plain 2:1 mux is enough
	assign resp.hit_0    = |hit_0;
	assign resp.target_0 = hit_0[0] ? way_q[0].target : way_q[1].target;
	assign resp.hit_1    = |hit_1;
	assign resp.target_1 = hit_1[0] ? way_q[0].target : way_q[1].target;

	always_comb begin
		way_d    = way_q;
		victim_d = victim_q;

		// lookup touches, port 1 has the last word
		if (hit_0[0]) begin
			victim_d = 1'b1;
		end else if (hit_0[1]) begin
			victim_d = 1'b0;
		end
		if (hit_1[0]) begin
			victim_d = 1'b1;
		end else if (hit_1[1]) begin
			victim_d = 1'b0;
		end

		// update port 0 on the touched state
		wr_way_0 = pick_way(way_d, victim_d, req.update_tag_0);
		if (req.update_sel_0) begin
			way_d[wr_way_0].valid  = 1'b1;
			way_d[wr_way_0].tag    = req.update_tag_0;
			way_d[wr_way_0].target = req.update_target_0;
			victim_d               = ~wr_way_0; // written way is now most recent
		end

		// update port 1 sees what port 0 left behind
		wr_way_1 = pick_way(way_d, victim_d, req.update_tag_1);
		if (req.update_sel_1) begin
			way_d[wr_way_1].valid  = 1'b1;
			way_d[wr_way_1].tag    = req.update_tag_1;
			way_d[wr_way_1].target = req.update_target_1;
			victim_d               = ~wr_way_1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			way_q[0].valid <= 1'b0;
			way_q[1].valid <= 1'b0;
			victim_q       <= 1'b0; // point at way 0
		end else begin
			way_q    <= way_d;
			victim_q <= victim_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/btb_settings.svh
`ifndef BTB_SETTINGS_SVH
`define BTB_SETTINGS_SVH

// geometry of the branch target buffer
`define BTB_SETS 16 // number of sets, power of two

// architectural pc width of the core
`define BTB_PC_WIDTH 64

`endif

//--- verilog/btb_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "btb_settings.svh"

module btb_top
	import btb_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  btb_lookup_t lookup_0, // fetch slot 0
	input  btb_lookup_t lookup_1, // fetch slot 1
	input  btb_update_t update_0, // resolve port 0
	input  btb_update_t update_1, // resolve port 1
	output btb_result_t result_0,
	output btb_result_t result_1
);

	btb_set_req_t  [`BTB_SETS-1:0] set_req; // decoder to sets
	btb_set_resp_t [`BTB_SETS-1:0] set_resp; // sets to selector

	btb_index_decode i_btb_index_decode (
		.lookup_0 (lookup_0),
		.lookup_1 (lookup_1),
		.update_0 (update_0),
		.update_1 (update_1),
		.set_req  (set_req)
	);

	// one set per index, all identical
	for (genvar s = 0; s < `BTB_SETS; s++) begin : g_set
		btb_set i_btb_set (
			.clock (clock),
			.reset (reset),
			.req   (set_req[s]),
			.resp  (set_resp[s])
		);
	end

	btb_hit_select i_btb_hit_select (
		.set_resp (set_resp),
		.result_0 (result_0),
		.result_1 (result_1)
	);

endmodule

`default_nettype wire
